// File: filelist.f
+incdir+source
source/log_reader_pkg.sv
source/log_store.sv
source/log_read_ctrl.sv
source/log_read_datap.sv
source/log_reader_top.sv
tb/log_reader_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the log reader testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module log_reader_tb -f filelist.f -o log_reader_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/log_reader_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: source/log_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module log_read_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic in_val,
    output logic in_rdy,
    output logic out_val,
    input  logic out_rdy,
    input  logic rd_meta,
    output logic store_meta,
    output logic store_req,
    output logic store_log_resp,
    output log_reader_pkg::resp_sel_e out_sel
);

    typedef enum logic [2:0] {
        RX_HDR,
        RX_META,
        RX_REQ,
        READ,
        CAPTURE,
        TX_HDR,
        TX_META,
        TX_RESP
    } state_e;

    state_e state;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RX_HDR;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        in_rdy = 1'b0;
        out_val = 1'b0;
        store_meta = 1'b0;
        store_req = 1'b0;
        store_log_resp = 1'b0;
        out_sel = log_reader_pkg::HDR;
        case (state)
            RX_HDR: begin
                in_rdy = 1'b1; // Header is dropped.
                if (in_val) state_next = RX_META;
            end
            RX_META: begin
                in_rdy = 1'b1;
                store_meta = in_val;
                if (in_val) state_next = RX_REQ;
            end
            RX_REQ: begin
                in_rdy = 1'b1;
                store_req = in_val;
                if (in_val) state_next = READ;
            end
            READ: begin
                // Pointer snapshot needs no memory access.
                store_log_resp = rd_meta;
                state_next = CAPTURE;
            end
            CAPTURE: begin
                store_log_resp = 1'b1; // Entry is out of the store.
                state_next = TX_HDR;
            end
            TX_HDR: begin
                out_val = 1'b1;
                out_sel = log_reader_pkg::HDR;
                if (out_rdy) state_next = TX_META;
            end
            TX_META: begin
                out_val = 1'b1;
                out_sel = log_reader_pkg::META;
                if (out_rdy) state_next = TX_RESP;
            end
            TX_RESP: begin
                out_val = 1'b1;
                out_sel = log_reader_pkg::RESP;
                if (out_rdy) state_next = RX_HDR;
            end
            default: begin
                state_next = RX_HDR;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/log_read_datap.sv
`timescale 1ns/1ps
`default_nettype none

`include "log_reader_macros.svh"

module log_read_datap #(
    parameter logic [`XY_WIDTH-1:0] SRC_X = '0,
    parameter logic [`XY_WIDTH-1:0] SRC_Y = '0,
    parameter logic [`XY_WIDTH-1:0] DST_X = '0,
    parameter logic [`XY_WIDTH-1:0] DST_Y = '0
) (
    input  logic clk,
    input  logic rst,
    input  log_reader_pkg::noc_flit_u in_data,
    output log_reader_pkg::noc_flit_u out_data,
    output logic [`LOG_ADDR_W-1:0] rd_addr,
    input  log_reader_pkg::log_entry_t rd_entry,
    input  logic [`LOG_ADDR_W-1:0] wr_ptr,
    input  logic wrapped,
    input  logic store_meta,
    input  logic store_req,
    input  logic store_log_resp,
    input  log_reader_pkg::resp_sel_e out_sel,
    output logic rd_meta
);

    localparam int RESP_PAYLOAD_W = `NOC_DATA_WIDTH - `CLIENT_ADDR_W;

    log_reader_pkg::udp_meta_flit meta_reg;
    logic [`CLIENT_ADDR_W-1:0] req_addr_reg;
    log_reader_pkg::log_entry_t entry_reg;
    logic [`CLIENT_ADDR_W-1:0] ptr_reg;
    logic [`CLIENT_ADDR_W-1:0] ptr_padded;

    log_reader_pkg::noc_hdr_flit hdr_flit;
    log_reader_pkg::udp_meta_flit tx_meta_flit;
    log_reader_pkg::log_resp_flit resp_flit;

    assign ptr_padded = {{(`CLIENT_ADDR_W-`LOG_ADDR_W-1){1'b0}}, wrapped, wr_ptr};

    assign rd_addr = req_addr_reg[`LOG_ADDR_W-1:0];
    assign rd_meta = req_addr_reg[`LOG_ADDR_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            req_addr_reg <= '0;
        end else if (store_req) begin
            req_addr_reg <= in_data.req.req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (store_meta) begin
            meta_reg <= in_data.meta;
        end
        if (store_log_resp) begin
            entry_reg <= rd_entry;
            ptr_reg <= ptr_padded;
        end
    end

    always_comb begin
        hdr_flit = '0;
        hdr_flit.dst_x = DST_X;
        hdr_flit.dst_y = DST_Y;
        hdr_flit.src_x = SRC_X;
        hdr_flit.src_y = SRC_Y;
        hdr_flit.msg_len = 8'd2; // Metadata plus response.
        hdr_flit.msg_type = `UDP_TX_SEGMENT;
        hdr_flit.metadata_flits = 8'd1;
    end

    // Reply goes back where the request came from.
    always_comb begin
        tx_meta_flit = '0;
        tx_meta_flit.src_ip = meta_reg.dst_ip;
        tx_meta_flit.dst_ip = meta_reg.src_ip;
        tx_meta_flit.src_port = meta_reg.dst_port;
        tx_meta_flit.dst_port = meta_reg.src_port;
        tx_meta_flit.data_length = 16'(`NOC_DATA_BYTES);
    end

    always_comb begin
        resp_flit = '0;
        resp_flit.resp_addr = req_addr_reg;
        if (rd_meta) begin
            resp_flit.resp_payload[RESP_PAYLOAD_W-1 -: `CLIENT_ADDR_W] = ptr_reg;
        end else begin
            resp_flit.resp_payload[RESP_PAYLOAD_W-1 -: `LOG_ENTRY_W] = entry_reg;
        end
    end

    always_comb begin
        case (out_sel)
            log_reader_pkg::HDR: out_data.hdr = hdr_flit;
            log_reader_pkg::META: out_data.meta = tx_meta_flit;
            default: out_data.resp = resp_flit;
        endcase
    end

endmodule

`default_nettype wire

// File: source/log_reader_macros.svh
`ifndef LOG_READER_MACROS_SVH
`define LOG_READER_MACROS_SVH

// NoC flit geometry.
`define NOC_DATA_WIDTH 128
`define NOC_DATA_BYTES 16
`define XY_WIDTH 4

// Log geometry of 64 entries.
`define LOG_ADDR_W 6
`define LOG_ENTRY_W 32

// Bit LOG_ADDR_W of the request address picks a pointer read.
`define CLIENT_ADDR_W 16

// Message type for a UDP transmit segment.
`define UDP_TX_SEGMENT 8'h12

`endif

// File: source/log_reader_pkg.sv
`default_nettype none

`include "log_reader_macros.svh"

package log_reader_pkg;

    typedef struct packed {
        logic [`XY_WIDTH-1:0] dst_x;
        logic [`XY_WIDTH-1:0] dst_y;
        logic [`XY_WIDTH-1:0] src_x;
        logic [`XY_WIDTH-1:0] src_y;
        logic [7:0] msg_len; // Flits after the header.
        logic [7:0] msg_type;
        logic [7:0] metadata_flits;
        logic [`NOC_DATA_WIDTH-4*`XY_WIDTH-25:0] padding;
    } noc_hdr_flit;

    // Same layout for receive and transmit.
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] data_length;
        logic [`NOC_DATA_WIDTH-113:0] padding;
    } udp_meta_flit;

    typedef struct packed {
        logic [`CLIENT_ADDR_W-1:0] req_addr;
        logic [`NOC_DATA_WIDTH-`CLIENT_ADDR_W-1:0] padding;
    } log_req_flit;

    typedef struct packed {
        logic [`CLIENT_ADDR_W-1:0] resp_addr;
        logic [`NOC_DATA_WIDTH-`CLIENT_ADDR_W-1:0] resp_payload;
    } log_resp_flit;

    // Decoded by position in the message.
    typedef union packed {
        noc_hdr_flit hdr;
        udp_meta_flit meta;
        log_req_flit req;
        log_resp_flit resp;
    } noc_flit_u;

    typedef enum logic [1:0] {
        HDR,
        META,
        RESP
    } resp_sel_e;

    typedef logic [`LOG_ENTRY_W-1:0] log_entry_t;

endpackage

`default_nettype wire

// File: source/log_reader_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "log_reader_macros.svh"

module log_reader_top #(
    parameter logic [`XY_WIDTH-1:0] SRC_X = '0,
    parameter logic [`XY_WIDTH-1:0] SRC_Y = '0,
    parameter logic [`XY_WIDTH-1:0] DST_X = '0,
    parameter logic [`XY_WIDTH-1:0] DST_Y = '0
) (
    input  logic clk,
    input  logic rst,
    input  logic in_val,
    input  log_reader_pkg::noc_flit_u in_data,
    output logic in_rdy,
    output logic out_val,
    output log_reader_pkg::noc_flit_u out_data,
    input  logic out_rdy,
    input  logic app_val,
    input  log_reader_pkg::log_entry_t app_entry
);

    logic store_meta;
    logic store_req;
    logic store_log_resp;
    logic rd_meta;
    log_reader_pkg::resp_sel_e out_sel;
    logic [`LOG_ADDR_W-1:0] rd_addr;
    log_reader_pkg::log_entry_t rd_entry;
    logic [`LOG_ADDR_W-1:0] wr_ptr;
    logic wrapped;

    log_read_ctrl ctrl (
        .clk(clk),
        .rst(rst),
        .in_val(in_val),
        .in_rdy(in_rdy),
        .out_val(out_val),
        .out_rdy(out_rdy),
        .rd_meta(rd_meta),
        .store_meta(store_meta),
        .store_req(store_req),
        .store_log_resp(store_log_resp),
        .out_sel(out_sel)
    );

    log_read_datap #(
        .SRC_X(SRC_X),
        .SRC_Y(SRC_Y),
        .DST_X(DST_X),
        .DST_Y(DST_Y)
    ) datap (
        .clk(clk),
        .rst(rst),
        .in_data(in_data),
        .out_data(out_data),
        .rd_addr(rd_addr),
        .rd_entry(rd_entry),
        .wr_ptr(wr_ptr),
        .wrapped(wrapped),
        .store_meta(store_meta),
        .store_req(store_req),
        .store_log_resp(store_log_resp),
        .out_sel(out_sel),
        .rd_meta(rd_meta)
    );

    log_store store (
        .clk(clk),
        .rst(rst),
        .app_val(app_val),
        .app_entry(app_entry),
        .rd_addr(rd_addr),
        .rd_entry(rd_entry),
        .wr_ptr(wr_ptr),
        .wrapped(wrapped)
    );

endmodule

`default_nettype wire

// File: source/log_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "log_reader_macros.svh"

module log_store (
    input  logic clk,
    input  logic rst,
    input  logic app_val,
    input  log_reader_pkg::log_entry_t app_entry,
    input  logic [`LOG_ADDR_W-1:0] rd_addr,
    output log_reader_pkg::log_entry_t rd_entry,
    output logic [`LOG_ADDR_W-1:0] wr_ptr,
    output logic wrapped
);

    localparam int DEPTH = 1 << `LOG_ADDR_W;

    log_reader_pkg::log_entry_t mem [0:DEPTH-1];

    // Pointer and sticky wrap flag.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            wrapped <= 1'b0;
        end else if (app_val) begin
            wr_ptr <= wr_ptr + 1'b1; // Rolls over modulo depth.
            if (&wr_ptr) begin
                wrapped <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (app_val) begin
            mem[wr_ptr] <= app_entry;
        end
    end

    // One cycle read latency.
    always_ff @(posedge clk) begin
        rd_entry <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: tb/log_reader_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "log_reader_macros.svh"

module log_reader_tb;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_PHASES = 12;
    localparam int PHASE_BOUND = 200; // Cycles for a burst, a request and its reply.
    localparam int PAYLOAD_W = `NOC_DATA_WIDTH - `CLIENT_ADDR_W;
    localparam logic [`XY_WIDTH-1:0] SRC_X = 4'd2;
    localparam logic [`XY_WIDTH-1:0] SRC_Y = 4'd3;
    localparam logic [`XY_WIDTH-1:0] DST_X = 4'd0;
    localparam logic [`XY_WIDTH-1:0] DST_Y = 4'd1;

    logic clk = 1'b0;
    logic rst;
    logic in_val;
    log_reader_pkg::noc_flit_u in_data;
    logic in_rdy;
    logic out_val;
    log_reader_pkg::noc_flit_u out_data;
    logic out_rdy;
    logic app_val;
    log_reader_pkg::log_entry_t app_entry;

    // Reference log.
    log_reader_pkg::log_entry_t model_mem [0:(1<<`LOG_ADDR_W)-1];
    logic [`LOG_ADDR_W-1:0] model_ptr;
    logic model_wrapped;

    integer seed;
    integer err_cnt;
    integer proto_cnt;
    integer phase;

    log_reader_top #(
        .SRC_X(SRC_X),
        .SRC_Y(SRC_Y),
        .DST_X(DST_X),
        .DST_Y(DST_Y)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .in_val(in_val),
        .in_data(in_data),
        .in_rdy(in_rdy),
        .out_val(out_val),
        .out_data(out_data),
        .out_rdy(out_rdy),
        .app_val(app_val),
        .app_entry(app_entry)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task report_failure(input string msg);
        $display("%s", msg);
        proto_cnt++;
    endtask

    task compare_field(input string name, input logic [`NOC_DATA_WIDTH-1:0] expected,
                       input logic [`NOC_DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0h, got %0h", name, expected, actual);
            err_cnt++;
        end
    endtask

    task check_hdr(input log_reader_pkg::noc_hdr_flit exp,
                   input log_reader_pkg::noc_hdr_flit act);
        compare_field("hdr.dst_x", 128'(exp.dst_x), 128'(act.dst_x));
        compare_field("hdr.dst_y", 128'(exp.dst_y), 128'(act.dst_y));
        compare_field("hdr.src_x", 128'(exp.src_x), 128'(act.src_x));
        compare_field("hdr.src_y", 128'(exp.src_y), 128'(act.src_y));
        compare_field("hdr.msg_len", 128'(exp.msg_len), 128'(act.msg_len));
        compare_field("hdr.msg_type", 128'(exp.msg_type), 128'(act.msg_type));
        compare_field("hdr.metadata_flits", 128'(exp.metadata_flits), 128'(act.metadata_flits));
        compare_field("hdr.padding", 128'(exp.padding), 128'(act.padding));
    endtask

    task check_meta(input log_reader_pkg::udp_meta_flit exp,
                    input log_reader_pkg::udp_meta_flit act);
        compare_field("meta.src_ip", 128'(exp.src_ip), 128'(act.src_ip));
        compare_field("meta.dst_ip", 128'(exp.dst_ip), 128'(act.dst_ip));
        compare_field("meta.src_port", 128'(exp.src_port), 128'(act.src_port));
        compare_field("meta.dst_port", 128'(exp.dst_port), 128'(act.dst_port));
        compare_field("meta.data_length", 128'(exp.data_length), 128'(act.data_length));
        compare_field("meta.padding", 128'(exp.padding), 128'(act.padding));
    endtask

    task check_resp(input log_reader_pkg::log_resp_flit exp,
                    input log_reader_pkg::log_resp_flit act);
        compare_field("resp.resp_addr", 128'(exp.resp_addr), 128'(act.resp_addr));
        compare_field("resp.resp_payload", 128'(exp.resp_payload), 128'(act.resp_payload));
    endtask

    // Entered and left on a falling edge.
    task append_burst(input integer count);
        integer i;
        for (i = 0; i < count; i++) begin
            app_val = 1'b1;
            app_entry = $random(seed);
            model_mem[model_ptr] = app_entry;
            if (model_ptr == 6'd63) model_wrapped = 1'b1;
            model_ptr = model_ptr + 6'd1;
            @(negedge clk);
        end
        app_val = 1'b0;
    endtask

    // Returns on the falling edge right after the accepting edge.
    task send_flit(input log_reader_pkg::noc_flit_u f);
        integer gap;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(negedge clk);
        in_val = 1'b1;
        in_data = f;
        while (!in_rdy) @(negedge clk);
        @(negedge clk);
        in_val = 1'b0;
    endtask

    task run_phase(input logic ptr_read);
        integer r;
        integer idx;
        integer avail;
        integer wait_cnt;
        integer nflit;
        logic first_seen;
        logic [`CLIENT_ADDR_W-1:0] addr;
        log_reader_pkg::noc_flit_u f;
        log_reader_pkg::udp_meta_flit rx_meta;
        log_reader_pkg::noc_flit_u got [0:2];
        log_reader_pkg::noc_hdr_flit exp_hdr;
        log_reader_pkg::udp_meta_flit exp_meta;
        log_reader_pkg::log_resp_flit exp_resp;

        while (!(in_rdy && !out_val)) @(negedge clk); // Idle.
        r = $random(seed);
        addr = r[`CLIENT_ADDR_W-1:0];
        addr[`LOG_ADDR_W] = ptr_read;
        if (!ptr_read) begin
            avail = model_wrapped ? 64 : 32'(model_ptr); // Written entries only.
            idx = $unsigned($random(seed)) % avail;
            addr[`LOG_ADDR_W-1:0] = idx[`LOG_ADDR_W-1:0];
        end

        f = {$random(seed), $random(seed), $random(seed), $random(seed)};
        send_flit(f);
        f = {$random(seed), $random(seed), $random(seed), $random(seed)};
        rx_meta = f.meta;
        send_flit(f);
        f = {$random(seed), $random(seed), $random(seed), $random(seed)};
        f.req.req_addr = addr;
        send_flit(f);

        wait_cnt = 1;
        nflit = 0;
        first_seen = 1'b0;
        while (nflit < 3) begin
            if (in_rdy) report_failure("in_rdy was high while a request was in service");
            if (out_val && !first_seen) begin
                first_seen = 1'b1;
                if (wait_cnt != 3) begin
                    report_failure($sformatf(
                        "first response flit came %0d cycles after the request, not 3",
                        wait_cnt));
                end
            end
            if (!out_val && first_seen) report_failure("out_val dropped in the middle of a response");
            out_rdy = ($unsigned($random(seed)) % 3) != 0;
            if (out_val && out_rdy) begin
                got[nflit] = out_data;
                nflit++;
            end
            @(negedge clk);
            wait_cnt++;
        end
        out_rdy = 1'b0;
        if (out_val) report_failure("a fourth response flit was offered");
        if (!in_rdy) report_failure("in_rdy stayed low after the last response flit");

        exp_hdr = '0;
        exp_hdr.dst_x = DST_X;
        exp_hdr.dst_y = DST_Y;
        exp_hdr.src_x = SRC_X;
        exp_hdr.src_y = SRC_Y;
        exp_hdr.msg_len = 8'd2;
        exp_hdr.msg_type = `UDP_TX_SEGMENT;
        exp_hdr.metadata_flits = 8'd1;

        exp_meta = '0;
        exp_meta.src_ip = rx_meta.dst_ip; // Swapped for the reply.
        exp_meta.dst_ip = rx_meta.src_ip;
        exp_meta.src_port = rx_meta.dst_port;
        exp_meta.dst_port = rx_meta.src_port;
        exp_meta.data_length = 16'(`NOC_DATA_BYTES);

        exp_resp = '0;
        exp_resp.resp_addr = addr;
        if (ptr_read) begin
            exp_resp.resp_payload[PAYLOAD_W-1 -: `CLIENT_ADDR_W] =
                {{(`CLIENT_ADDR_W-`LOG_ADDR_W-1){1'b0}}, model_wrapped, model_ptr};
        end else begin
            exp_resp.resp_payload[PAYLOAD_W-1 -: `LOG_ENTRY_W] =
                model_mem[addr[`LOG_ADDR_W-1:0]];
        end

        check_hdr(exp_hdr, got[0].hdr);
        check_meta(exp_meta, got[1].meta);
        check_resp(exp_resp, got[2].resp);
    endtask

    initial begin
        #((NUM_PHASES * PHASE_BOUND + 10) * CLK_PERIOD);
        $display("Watchdog expired before the test phases were finished.");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seed = 80;
        err_cnt = 0;
        proto_cnt = 0;
        rst = 1'b1;
        in_val = 1'b0;
        in_data = '0;
        out_rdy = 1'b0;
        app_val = 1'b0;
        app_entry = '0;
        model_ptr = '0;
        model_wrapped = 1'b0;

        repeat (3) @(negedge clk);
        rst = 1'b0;
        if (out_val) report_failure("out_val was high after reset");
        if (!in_rdy) report_failure("in_rdy was low after reset");

        // First phase reads the pointer before the wrap, last one after it.
        for (phase = 0; phase < NUM_PHASES; phase++) begin
            append_burst(8 + $unsigned($random(seed)) % 8);
            run_phase((phase == 0) || (phase == NUM_PHASES-1) || ($random(seed) & 1) != 0);
        end

        $display("Summary: %0d value errors, %0d protocol errors", err_cnt, proto_cnt);
        if (err_cnt == 0 && proto_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
